/* vlog.f */
+incdir+include
verilog/ps2_pkg.sv
verilog/apb_pkg.sv
verilog/ps2_apb_regs.sv
verilog/ps2_port.sv
verilog/ps2_rx_collect.sv
verilog/ps2_host_top.sv
dv/ps2_device_model.sv
dv/tb_ps2_host.sv

/* dv/tb_ps2_host.sv */
/*
 * testbench for the PS/2 host, one device model and pull-ups per port
 * assumes a 4 ns sys_clk and at least two ports
 * stops at the first mismatch
 */
`include "ps2_config.svh"

module tb_ps2_host;
	timeunit 1ns;
	timeprecision 100ps;
	import ps2_pkg::*;
	import apb_pkg::*;

	localparam int NP     = `PS2_NUM_PORTS;
	localparam int AW     = `PS2_APB_AW;
	localparam int BIT_NS = `PS2_TICK_DIV * 16 * 4;  // 16 ticks per device bit
	localparam int INH_NS = `PS2_INHIBIT_TICKS * `PS2_TICK_DIV * 4;
	localparam int FRAMES = 10;  // device plus host frames over all tests

	logic          sys_clk;
	logic          sys_rst;
	apb_req_t      apb_req;
	apb_rsp_t      apb_rsp;
	wire  [NP-1:0] ps2_clk;
	wire  [NP-1:0] ps2_data;
	logic          irq;
	logic [NP-1:0] send_go;
	logic [NP-1:0] send_bad_par;
	logic [7:0]    send_byte [NP];
	int            sent_count [NP];
	logic [7:0]    recv_byte [NP];
	logic [NP-1:0] recv_ok;
	int            recv_count [NP];
	string         test_name;
	int            good_unread [NP];  // good frames since the last DATA read
	int            lost [NP];         // overwritten bytes since overrun clear
	int            bad [NP];          // bad frames since frame_err clear
	logic          irq_en [NP];
	logic [7:0]    exp_q [NP][$];     // good bytes, last one is readable

	ps2_host_top i_dut (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.irq      (irq)
	);

	for (genvar p = 0; p < NP; p++) begin : g_dev
		pullup (ps2_clk[p]);
		pullup (ps2_data[p]);
		ps2_device_model u_dev (
			.ps2_clk      (ps2_clk[p]),
			.ps2_data     (ps2_data[p]),
			.send_go      (send_go[p]),
			.send_byte    (send_byte[p]),
			.send_bad_par (send_bad_par[p]),
			.sent_count   (sent_count[p]),
			.recv_byte    (recv_byte[p]),
			.recv_ok      (recv_ok[p]),
			.recv_count   (recv_count[p])
		);
	end

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			fail_now($sformatf("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, exp, act));
		end
	endtask

	task automatic check_status(input string name, input ps2_flags_t exp, input ps2_flags_t act);
		if (act !== exp) begin
			fail_now($sformatf("[FAIL] %s: {pend,ovr,ferr,irq_en} expected %b, actual %b",
				name, exp, act));
		end
	endtask

	task automatic check_rsp(input string name, input logic exp_err, input apb_rsp_t act);
		if (act.pslverr !== exp_err || act.pready !== 1'b1) begin
			fail_now($sformatf("[FAIL] %s: pslverr expected %b, actual %b (pready %b)",
				name, exp_err, act.pslverr, act.pready));
		end
	endtask

	task automatic check_port(input string name, input ps2_port_status_t exp,
				  input ps2_port_status_t act);
		if (act !== exp) begin
			fail_now($sformatf("[FAIL] %s: {busy,ack_err} expected %b, actual %b",
				name, exp, act));
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_now($sformatf("[FAIL] %s: irq expected %b, actual %b", name, exp, act));
		end
	endtask

	function automatic ps2_flags_t expected_status(input int p);
		ps2_flags_t f;
		f.pending   = (good_unread[p] > 0);
		f.overrun   = (lost[p] > 0);
		f.frame_err = (bad[p] > 0);
		f.irq_en    = irq_en[p];
		return f;
	endfunction

	function automatic logic expected_irq();
		logic level;
		level = 1'b0;
		for (int p = 0; p < NP; p++) begin
			level |= (good_unread[p] > 0) & irq_en[p];
		end
		return level;
	endfunction

	function automatic void score_frame(input int p, input logic [7:0] b, input logic bad_par);
		if (bad_par) begin
			bad[p]++;
		end else begin
			if (good_unread[p] > 0) begin
				lost[p]++;  // unread byte gets overwritten
			end
			good_unread[p]++;
			exp_q[p].push_back(b);
		end
	endfunction

	// setup then access phase, response taken mid access cycle
	task automatic apb_xfer(input logic wr, input int port, input ps2_reg_e r,
				input logic [31:0] wdata, output apb_rsp_t rsp);
		@(posedge sys_clk);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= AW'(port * 16 + int'(r) * 4);
		apb_req.pwdata  <= wdata;
		@(posedge sys_clk);
		apb_req.penable <= 1'b1;
		@(negedge sys_clk);
		rsp = apb_rsp;
		@(posedge sys_clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic write_reg(input int p, input ps2_reg_e r, input logic [31:0] wdata,
				 input logic exp_err);
		apb_rsp_t rsp;
		apb_xfer(1'b1, p, r, wdata, rsp);
		check_rsp({test_name, " write"}, exp_err, rsp);
	endtask

	task automatic read_data(input int p);
		apb_rsp_t rsp;
		apb_xfer(1'b0, p, REG_DATA, '0, rsp);  // byte checked by the monitor
		check_rsp({test_name, " data read"}, 1'b0, rsp);
	endtask

	task automatic read_status(input int p, output ps2_flags_t f, output ps2_port_status_t s);
		apb_rsp_t rsp;
		apb_xfer(1'b0, p, REG_STATUS, '0, rsp);
		check_rsp({test_name, " status read"}, 1'b0, rsp);
		f.pending    = rsp.prdata[0];
		f.overrun    = rsp.prdata[1];
		f.frame_err  = rsp.prdata[2];
		s.tx_busy    = rsp.prdata[3];
		s.tx_ack_err = rsp.prdata[4];
		apb_xfer(1'b0, p, REG_CTRL, '0, rsp);
		f.irq_en = rsp.prdata[0];
	endtask

	task automatic verify_status(input int p);
		ps2_flags_t       f;
		ps2_port_status_t s;
		read_status(p, f, s);
		check_status($sformatf("%s port %0d", test_name, p), expected_status(p), f);
	endtask

	// pending to irq is one cycle, a read clear shows up one cycle later
	task automatic settle_irq(input string name);
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		check_irq(name, expected_irq(), irq);
	endtask

	// device frame on port p, scoreboard updated when the device is done
	task automatic device_frame(input int p, input logic [7:0] b, input logic bad_par);
		int n;
		n = sent_count[p];
		@(posedge sys_clk);
		send_byte[p]    <= b;
		send_bad_par[p] <= bad_par;
		send_go[p]      <= 1'b1;
		@(posedge sys_clk);
		send_go[p] <= 1'b0;
		wait (sent_count[p] == n + 1);
		score_frame(p, b, bad_par);
	endtask

	// compares every DATA read against the byte scoreboard
	always @(negedge sys_clk) begin
		int         p;
		logic [7:0] held;
		p = int'(apb_req.paddr[AW-1:4]);
		if (!sys_rst && apb_req.psel && apb_req.penable && !apb_req.pwrite &&
		    apb_req.paddr[3:2] == REG_DATA && p < NP) begin
			if (exp_q[p].size() == 0) begin
				fail_now("DATA was read before any byte had arrived on that port");
			end
			held = exp_q[p][$];
			check_byte({test_name, " data"}, held, apb_rsp.prdata[7:0]);
			exp_q[p].delete();
			exp_q[p].push_back(held);  // holding register keeps it
			good_unread[p] = 0;
		end
	end

	initial begin
		#((FRAMES * 12 * BIT_NS + INH_NS) * 3);
		fail_now("timeout: device frames did not complete");
	end

	initial begin
		ps2_port_status_t s;
		ps2_flags_t       f;
		apb_rsp_t         rsp;
		logic [7:0]       b;
		logic [7:0]       b1;
		int               n;
		void'($urandom(95));
		sys_rst      = 1'b1;
		apb_req      = '0;
		send_go      = '0;
		send_bad_par = '0;
		test_name    = "reset";
		for (int p = 0; p < NP; p++) begin
			send_byte[p]   = '0;
			good_unread[p] = 0;
			lost[p]        = 0;
			bad[p]         = 0;
			irq_en[p]      = 1'b0;
		end
		repeat (5) @(posedge sys_clk);
		sys_rst <= 1'b0;
		settle_irq(test_name);

		test_name = "rx_each_port";
		for (int p = 0; p < NP; p++) begin
			device_frame(p, 8'($urandom), 1'b0);
			verify_status(p);  // pending set
			read_data(p);
			verify_status(p);  // pending cleared by the read
		end

		test_name = "irq_enable";
		write_reg(0, REG_CTRL, 32'h1, 1'b0);
		irq_en[0] = 1'b1;
		device_frame(1, 8'($urandom), 1'b0);
		settle_irq({test_name, " disabled port"});
		read_data(1);
		device_frame(0, 8'($urandom), 1'b0);
		settle_irq({test_name, " enabled port"});
		read_data(0);
		settle_irq({test_name, " after read"});
		write_reg(0, REG_CTRL, 32'h0, 1'b0);
		irq_en[0] = 1'b0;

		test_name = "overrun";
		device_frame(0, 8'($urandom), 1'b0);
		device_frame(0, 8'($urandom), 1'b0);
		verify_status(0);
		read_data(0);  // second byte expected
		write_reg(0, REG_STATUS, 32'h2, 1'b0);
		lost[0] = 0;
		verify_status(0);

		test_name = "parity_error";
		device_frame(0, 8'($urandom), 1'b1);
		verify_status(0);  // frame_err only
		read_data(0);      // old byte unchanged
		write_reg(0, REG_STATUS, 32'h4, 1'b0);
		bad[0] = 0;
		verify_status(0);

		test_name = "host_tx";
		b = 8'($urandom);
		n = recv_count[0];
		write_reg(0, REG_DATA, {24'h0, b}, 1'b0);
		write_reg(0, REG_DATA, 32'h5a, 1'b1);  // port busy, refused
		wait (recv_count[0] == n + 1);
		check_byte({test_name, " device byte"}, b, recv_byte[0]);
		if (recv_ok[0] !== 1'b1) begin
			fail_now("device saw a bad start, parity or stop bit in the host frame");
		end
		for (int i = 0; i < 50; i++) begin
			read_status(0, f, s);
			if (!s.tx_busy) begin
				break;
			end
		end
		check_port(test_name, '{tx_busy: 1'b0, tx_ack_err: 1'b0}, s);

		test_name = "both_ports";
		b  = 8'($urandom);
		b1 = 8'($urandom);
		fork
			device_frame(0, b, 1'b0);
			device_frame(1, b1, 1'b0);
		join
		for (int p = 0; p < NP; p++) begin
			verify_status(p);
			read_data(p);
		end
		apb_xfer(1'b0, NP, REG_STATUS, '0, rsp);
		check_rsp({test_name, " past last port"}, 1'b1, rsp);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* dv/ps2_device_model.sv */
/*
 * behavioral PS/2 device, open-drain drive on clock and data
 * bit period is 16 host sampling ticks at a 4 ns sys_clk
 * a host inhibit is only noticed while no device frame is in flight
 */
`include "ps2_config.svh"

module ps2_device_model (
	inout  wire        ps2_clk,
	inout  wire        ps2_data,
	input  logic       send_go,       // rising edge starts a device frame
	input  logic [7:0] send_byte,
	input  logic       send_bad_par,  // flip the parity bit
	output int         sent_count,
	output logic [7:0] recv_byte,
	output logic       recv_ok,       // start, odd parity and stop bits seen from host
	output int         recv_count
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_NS = `PS2_TICK_DIV * 8 * 4;  // half bit, 8 ticks

	logic clk_low;
	logic data_low;

	assign ps2_clk  = clk_low ? 1'b0 : 1'bz;  // pullup in the testbench
	assign ps2_data = data_low ? 1'b0 : 1'bz;

	// device to host, start 0, data lsb first, odd parity, stop 1
	task automatic send_frame(input logic [7:0] b, input logic bad);
		logic [10:0] bits;
		bits = {1'b1, (~^b) ^ bad, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			data_low = ~bits[i];  // change data while clock is high
			#(HALF_NS);
			clk_low = 1'b1;
			#(HALF_NS);
			clk_low = 1'b0;
		end
		data_low = 1'b0;
		#(4 * HALF_NS);  // idle gap, host has latched the byte by now
		sent_count++;
	endtask

	// host to device, entered with the host holding the clock low
	task automatic recv_frame();
		logic [9:0] bits;
		logic       start_bit;
		@(posedge ps2_clk);  // inhibit over, data should already be low
		start_bit = ps2_data;  // request-to-send start bit
		#(HALF_NS);
		for (int i = 0; i < 10; i++) begin
			clk_low = 1'b1;
			#(HALF_NS);
			clk_low = 1'b0;
			#1;
			bits[i] = ps2_data;  // host drove it during clock low
			#(HALF_NS - 1);
		end
		data_low = 1'b1;  // ack bit
		clk_low  = 1'b1;
		#(HALF_NS);
		clk_low = 1'b0;
		#(HALF_NS);
		data_low   = 1'b0;
		recv_byte  = bits[7:0];
		recv_ok    = ~start_bit & (^bits[8:0]) & bits[9];
		recv_count++;
	endtask

	initial begin
		clk_low    = 1'b0;
		data_low   = 1'b0;
		sent_count = 0;
		recv_count = 0;
		recv_byte  = '0;
		recv_ok    = 1'b0;
		forever begin
			@(posedge send_go or negedge ps2_clk);
			if (ps2_clk === 1'b0) begin
				recv_frame();  // host pulled the clock, not us
			end else if (send_go === 1'b1) begin
				send_frame(send_byte, send_bad_par);
			end
		end
	end

endmodule

/* verilog/ps2_host_top.sv */
/*
 * multi-port PS/2 host on APB with one level interrupt
 * pins are open drain, board pull-ups are required on clock and data
 */
`include "ps2_config.svh"

module ps2_host_top (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  apb_pkg::apb_req_t         apb_req,
	output apb_pkg::apb_rsp_t         apb_rsp,
	inout  wire [`PS2_NUM_PORTS-1:0]  ps2_clk,
	inout  wire [`PS2_NUM_PORTS-1:0]  ps2_data,
	output logic                      irq
);
	import ps2_pkg::*;

	ps2_tx_req_t               tx_req [`PS2_NUM_PORTS];
	ps2_port_status_t          port_status [`PS2_NUM_PORTS];
	ps2_rx_event_t             rx_event [`PS2_NUM_PORTS];
	ps2_flags_t                flags [`PS2_NUM_PORTS];
	logic [7:0]                rx_byte [`PS2_NUM_PORTS];
	logic                      flag_wr;
	logic                      data_rd;
	ps2_port_idx_t             flag_port;
	logic [2:0]                flag_wdata;
	logic [`PS2_NUM_PORTS-1:0] clk_oe;
	logic [`PS2_NUM_PORTS-1:0] data_oe;

	ps2_apb_regs u_regs (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.tx_req      (tx_req),
		.port_status (port_status),
		.flags       (flags),
		.rx_byte     (rx_byte),
		.flag_wr     (flag_wr),
		.flag_port   (flag_port),
		.flag_wdata  (flag_wdata),
		.data_rd     (data_rd)
	);

	for (genvar i = 0; i < `PS2_NUM_PORTS; i++) begin : g_port
		ps2_port u_port (
			.sys_clk  (sys_clk),
			.sys_rst  (sys_rst),
			.tx_req   (tx_req[i]),
			.status   (port_status[i]),
			.rx_event (rx_event[i]),
			.line_in  ({ps2_clk[i], ps2_data[i]}),
			.clk_oe   (clk_oe[i]),
			.data_oe  (data_oe[i])
		);

		assign ps2_clk[i]  = clk_oe[i]  ? 1'b0 : 1'bz;  // pull low or float
		assign ps2_data[i] = data_oe[i] ? 1'b0 : 1'bz;
	end

	ps2_rx_collect u_collect (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.rx_event   (rx_event),
		.flag_wr    (flag_wr),
		.data_rd    (data_rd),
		.flag_port  (flag_port),
		.flag_wdata (flag_wdata),
		.flags      (flags),
		.rx_byte    (rx_byte),
		.irq        (irq)
	);

endmodule

/* verilog/ps2_rx_collect.sv */
/*
 * per-port receive holding register, sticky flags and the interrupt
 * one byte per port, a new byte overwrites an unread one and sets overrun
 * irq is registered, one cycle behind pending
 */
`include "ps2_config.svh"

module ps2_rx_collect (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  ps2_pkg::ps2_rx_event_t rx_event [`PS2_NUM_PORTS],
	input  logic                   flag_wr,
	input  logic                   data_rd,
	input  ps2_pkg::ps2_port_idx_t flag_port,
	input  logic [2:0]             flag_wdata,
	output ps2_pkg::ps2_flags_t    flags [`PS2_NUM_PORTS],
	output logic [7:0]             rx_byte [`PS2_NUM_PORTS],
	output logic                   irq
);
	import ps2_pkg::*;

	logic [`PS2_NUM_PORTS-1:0] irq_src;

	for (genvar i = 0; i < `PS2_NUM_PORTS; i++) begin : g_port
		logic wr_hit;
		logic rd_hit;

		assign wr_hit = flag_wr & (flag_port == ps2_port_idx_t'(i));
		assign rd_hit = data_rd & (flag_port == ps2_port_idx_t'(i));

		always_ff @(posedge sys_clk) begin
			if (sys_rst) begin
				flags[i] <= '0;
			end else begin
				if (wr_hit) begin
					flags[i].irq_en <= flag_wdata[0];
					if (flag_wdata[1]) begin
						flags[i].overrun <= 1'b0;  // write 1 to clear
					end
					if (flag_wdata[2]) begin
						flags[i].frame_err <= 1'b0;
					end
				end
				if (rd_hit) begin
					flags[i].pending <= 1'b0;  // data read clears
				end
				// new events after the clears so they win
				if (rx_event[i].rx_valid) begin
					flags[i].pending <= 1'b1;
					if (flags[i].pending && !rd_hit) begin
						flags[i].overrun <= 1'b1;  // old byte lost unread
					end
				end
				if (rx_event[i].frame_err) begin
					flags[i].frame_err <= 1'b1;
				end
			end
		end

		always_ff @(posedge sys_clk) begin
			if (rx_event[i].rx_valid) begin
				rx_byte[i] <= rx_event[i].data;  // bad frames leave it alone
			end
		end

		assign irq_src[i] = flags[i].pending & flags[i].irq_en;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq <= 1'b0;
		end else begin
			irq <= |irq_src;
		end
	end

endmodule

/* verilog/ps2_port.sv */
/*
 * one PS/2 host port, device clocked, open-drain drive via clk_oe/data_oe
 * a transmit request aborts any partial receive frame
 * no timeout while waiting for the device to clock a transmit,
 * a missing device keeps tx_busy set
 */
`include "ps2_config.svh"

module ps2_port (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  ps2_pkg::ps2_tx_req_t      tx_req,
	output ps2_pkg::ps2_port_status_t status,
	output ps2_pkg::ps2_rx_event_t    rx_event,
	input  logic [1:0]                line_in,
	output logic                      clk_oe,
	output logic                      data_oe
);
	import ps2_pkg::*;

	localparam int DIV_W        = $clog2(`PS2_TICK_DIV);
	localparam int RUN_W        = $clog2(`PS2_IDLE_TICKS + 1);
	localparam int INH_W        = $clog2(`PS2_INHIBIT_TICKS);
	localparam int SAMPLE_TICKS = 4;  // data taken this far into clock low

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	ps2_line_t        line_s1;
	ps2_line_t        line_s2;
	logic             clk_level;  // filtered clock
	logic [RUN_W-1:0] run_cnt;    // ticks since clk_level last changed
	logic             sample_pt;
	logic             clk_fall;
	logic             idle_out;
	logic [3:0]       bit_cnt;
	ps2_frame_t       rx_shift;
	ps2_frame_t       rx_frame;
	logic             frame_ok;
	ps2_frame_t       tx_frame;
	logic [9:0]       tx_bits;
	logic [INH_W-1:0] inh_cnt;
	ps2_tx_state_e    state;
	logic             clk_low;
	logic             data_low;
	logic             ack_err;

	assign tick = (div_cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			div_cnt <= DIV_W'(`PS2_TICK_DIV - 1);
		end else if (tick) begin
			div_cnt <= DIV_W'(`PS2_TICK_DIV - 1);
		end else begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			line_s1 <= '1;  // idle bus is high
			line_s2 <= '1;
		end else begin
			line_s1 <= ps2_line_t'(line_in);
			line_s2 <= line_s1;
		end
	end

	// clock level and run length, doubles as glitch filter and idle timer
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			clk_level <= 1'b1;
			run_cnt   <= '0;
		end else if (tick) begin
			if (line_s2.clk != clk_level) begin
				clk_level <= line_s2.clk;
				run_cnt   <= '0;
			end else if (run_cnt != RUN_W'(`PS2_IDLE_TICKS)) begin
				run_cnt <= run_cnt + 1'b1;  // saturates at the idle limit
			end
		end
	end

	assign sample_pt = tick & ~clk_level & (run_cnt == RUN_W'(SAMPLE_TICKS));
	assign clk_fall  = tick & ~clk_level & (run_cnt == '0);  // first tick after a fall
	assign idle_out  = tick & (run_cnt == RUN_W'(`PS2_IDLE_TICKS));

	assign rx_frame = ps2_frame_t'({line_s2.data, rx_shift[10:1]});
	assign frame_ok = ~rx_frame.start & rx_frame.stop & (^{rx_frame.data, rx_frame.parity});
	assign tx_bits  = {tx_frame.stop, tx_frame.parity, tx_frame.data};  // start bit is the rts

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= TX_IDLE;
			bit_cnt  <= '0;
			inh_cnt  <= '0;
			clk_low  <= 1'b0;
			data_low <= 1'b0;
			ack_err  <= 1'b0;
			rx_event <= '0;
		end else begin
			rx_event.rx_valid  <= 1'b0;
			rx_event.frame_err <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_req.start) begin
						tx_frame <= {1'b1, ~^tx_req.data, tx_req.data, 1'b0};
						state    <= TX_INHIBIT;
						clk_low  <= 1'b1;
						inh_cnt  <= '0;
						bit_cnt  <= '0;  // drop any partial rx frame
					end else if (sample_pt) begin
						rx_shift <= rx_frame;
						if (bit_cnt == 4'd10) begin
							bit_cnt            <= '0;
							rx_event.data      <= rx_frame.data;
							rx_event.rx_valid  <= frame_ok;
							rx_event.frame_err <= ~frame_ok;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else if (idle_out) begin
						bit_cnt <= '0;  // clock stalled mid frame
					end
				end
				TX_INHIBIT: begin
					if (tick) begin
						if (inh_cnt == INH_W'(`PS2_INHIBIT_TICKS - 2)) begin
							data_low <= 1'b1;  // start bit while clock still held
						end
						if (inh_cnt == INH_W'(`PS2_INHIBIT_TICKS - 1)) begin
							state   <= TX_RTS;
							clk_low <= 1'b0;  // hand the clock to the device
						end else begin
							inh_cnt <= inh_cnt + 1'b1;
						end
					end
				end
				TX_RTS, TX_SHIFT: begin
					if (clk_fall) begin
						data_low <= ~tx_bits[bit_cnt];  // stop bit releases data
						if (bit_cnt == 4'd9) begin
							state   <= TX_ACK;
							bit_cnt <= '0;
						end else begin
							state   <= TX_SHIFT;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				TX_ACK: begin
					// 0 waits for the ack clock, 1 samples, 2 waits for clock release
					if (bit_cnt == 4'd0 && clk_fall) begin
						bit_cnt <= 4'd1;
					end else if (bit_cnt == 4'd1 && sample_pt) begin
						ack_err <= line_s2.data;  // device should hold data low
						bit_cnt <= 4'd2;
					end else if (bit_cnt == 4'd2 && tick && clk_level) begin
						state   <= TX_IDLE;
						bit_cnt <= '0;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	assign status.tx_busy    = (state != TX_IDLE);
	assign status.tx_ack_err = ack_err;
	assign clk_oe            = clk_low;
	assign data_oe           = data_low;

	a_clk_oe_inhibit: assert property (@(posedge sys_clk) disable iff (sys_rst)
		clk_oe |-> state == TX_INHIBIT);

	// rx results are exclusive single-cycle pulses
	a_rx_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(rx_event.rx_valid || rx_event.frame_err) |->
		!(rx_event.rx_valid && rx_event.frame_err) ##1
		!(rx_event.rx_valid || rx_event.frame_err));

endmodule

/* verilog/ps2_apb_regs.sv */
/*
 * APB slave for all PS/2 ports, no wait states
 * response and strobes are combinational in the access phase
 * DATA write to a busy port and any access past the last port give pslverr
 * offset 3 in a window reads as zero and ignores writes
 */
`include "ps2_config.svh"

module ps2_apb_regs (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  apb_pkg::apb_req_t         apb_req,
	output apb_pkg::apb_rsp_t         apb_rsp,
	output ps2_pkg::ps2_tx_req_t      tx_req [`PS2_NUM_PORTS],
	input  ps2_pkg::ps2_port_status_t port_status [`PS2_NUM_PORTS],
	input  ps2_pkg::ps2_flags_t       flags [`PS2_NUM_PORTS],
	input  logic [7:0]                rx_byte [`PS2_NUM_PORTS],
	output logic                      flag_wr,
	output ps2_pkg::ps2_port_idx_t    flag_port,
	output logic [2:0]                flag_wdata,
	output logic                      data_rd
);
	import apb_pkg::*;
	import ps2_pkg::*;

	localparam int ADDR_MSB = `PS2_APB_AW - 1;

	logic             access;
	logic             port_hit;
	logic             wr_ok;
	logic             tx_refuse;
	ps2_port_idx_t    port_idx;
	ps2_reg_e         reg_sel;
	ps2_flags_t       sel_flags;
	ps2_port_status_t sel_status;

	assign access   = apb_req.psel & apb_req.penable;  // second cycle of the transfer
	assign port_hit = (apb_req.paddr[ADDR_MSB:4] < `PS2_NUM_PORTS);
	assign port_idx = apb_req.paddr[4 +: PS2_PW];
	assign reg_sel  = ps2_reg_e'(apb_req.paddr[3:2]);

	assign sel_flags  = flags[port_idx];
	assign sel_status = port_status[port_idx];

	assign tx_refuse = apb_req.pwrite & (reg_sel == REG_DATA) & sel_status.tx_busy;
	assign wr_ok     = access & port_hit & apb_req.pwrite;

	always_comb begin
		apb_rsp.prdata  = '0;
		apb_rsp.pready  = 1'b1;  // never stretches
		apb_rsp.pslverr = access & (~port_hit | tx_refuse);
		if (access && port_hit && !apb_req.pwrite) begin
			case (reg_sel)
				REG_DATA:   apb_rsp.prdata[7:0] = rx_byte[port_idx];
				REG_STATUS: apb_rsp.prdata[4:0] = {sel_status.tx_ack_err,
								  sel_status.tx_busy,
								  sel_flags.frame_err,
								  sel_flags.overrun,
								  sel_flags.pending};
				REG_CTRL:   apb_rsp.prdata[0] = sel_flags.irq_en;
				default:    apb_rsp.prdata = '0;
			endcase
		end
	end

	// strobes to the collector, port index shared by read and write
	assign data_rd   = access & port_hit & ~apb_req.pwrite & (reg_sel == REG_DATA);
	assign flag_wr   = wr_ok & ((reg_sel == REG_STATUS) | (reg_sel == REG_CTRL));
	assign flag_port = port_idx;

	// status writes carry irq_en back unchanged in bit 0
	assign flag_wdata = (reg_sel == REG_CTRL) ? {2'b00, apb_req.pwdata[0]}
						  : {apb_req.pwdata[2:1], sel_flags.irq_en};

	for (genvar i = 0; i < `PS2_NUM_PORTS; i++) begin : g_tx
		assign tx_req[i].start = wr_ok & (reg_sel == REG_DATA) & ~tx_refuse &
					 (port_idx == ps2_port_idx_t'(i));
		assign tx_req[i].data  = apb_req.pwdata[7:0];

		// a granted request must find the port idle and make it busy next cycle
		a_tx_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
			tx_req[i].start |-> !port_status[i].tx_busy ##1 port_status[i].tx_busy);
	end

	a_penable_psel: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(apb_req.penable) |-> apb_req.psel);

endmodule

/* verilog/apb_pkg.sv */
/*
 * APB request and response bundles plus the register map
 * each port owns a 16-byte window, bits 3:2 pick the register
 * no pprot or pstrb, all accesses are full words
 */
`include "ps2_config.svh"

package apb_pkg;

	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`PS2_APB_AW-1:0] paddr;
		logic [31:0]            pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		REG_DATA   = 2'd0,  // rx byte on read, tx byte on write
		REG_STATUS = 2'd1,  // flags, write 1 to clear errors
		REG_CTRL   = 2'd2   // bit 0 irq enable
	} ps2_reg_e;

endpackage

/* verilog/ps2_pkg.sv */
/*
 * PS/2 line, frame and event types shared by the port engines,
 * the register block and the receive collector
 * port index width is at least one bit, even with a single port
 */
`include "ps2_config.svh"

package ps2_pkg;

	localparam int PS2_PW = (`PS2_NUM_PORTS > 1) ? $clog2(`PS2_NUM_PORTS) : 1;

	typedef logic [PS2_PW-1:0] ps2_port_idx_t;

	typedef struct packed {
		logic clk;   // device clock line
		logic data;  // device data line
	} ps2_line_t;

	// 11-bit frame as it comes off the wire, lsb first
	typedef struct packed {
		logic       stop;
		logic       parity;  // odd parity over data
		logic [7:0] data;
		logic       start;
	} ps2_frame_t;

	typedef struct packed {
		logic       start;  // one-cycle request
		logic [7:0] data;
	} ps2_tx_req_t;

	typedef struct packed {
		logic tx_busy;
		logic tx_ack_err;  // device did not pull data low on the ack clock
	} ps2_port_status_t;

	typedef struct packed {
		logic       rx_valid;   // good frame, one cycle
		logic [7:0] data;
		logic       frame_err;  // bad start, parity or stop, one cycle
	} ps2_rx_event_t;

	typedef struct packed {
		logic pending;
		logic overrun;
		logic frame_err;
		logic irq_en;
	} ps2_flags_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_INHIBIT,
		TX_RTS,
		TX_SHIFT,
		TX_ACK
	} ps2_tx_state_e;

endpackage

/* include/ps2_config.svh */
/*
 * build-time parameters for the multi-port PS/2 host
 * tick and timeout values are in sampling ticks, not system clocks
 * PS2_IDLE_TICKS must exceed a half bit period of the slowest device
 * PS2_TICK_DIV and PS2_INHIBIT_TICKS must both be at least 2
 */
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

`define PS2_NUM_PORTS     2   // identical port engines behind one APB slave
`define PS2_TICK_DIV      8   // sys_clk cycles per sampling tick
`define PS2_INHIBIT_TICKS 64  // clock held low before request-to-send
`define PS2_IDLE_TICKS    40  // steady clock this long drops a partial frame
`define PS2_APB_AW        12  // byte address width on APB

`endif
